/* design/sim_bus_pkg.sv */
// Shared bus types, address map and test utility encodings.
// RamSizeWords must stay a power of two so the RAM decode mask is contiguous.
package sim_bus_pkg;

  localparam int unsigned NrHosts   = 3;
  localparam int unsigned NrDevices = 2;

  // 4 kB RAM
  localparam int unsigned RamSizeWords = 1024;
  localparam int unsigned RamAddrWidth = $clog2(RamSizeWords);

  // Decode is (addr & mask) == base
  localparam logic [31:0] RamBase      = 32'h0000_0000;
  localparam logic [31:0] RamMask      = ~32'(RamSizeWords * 4 - 1);
  localparam logic [31:0] TestUtilBase = 32'h0002_0000;
  localparam logic [31:0] TestUtilMask = ~32'h0000_03FF;

  // Offset bits inside the 1 kB test utility window
  localparam int unsigned TuOffsetWidth = 10;

  // Request payload from a host, forwarded unchanged to a device
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } bus_req_t;

  // Response payload, meaningful only while rvalid is high
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } bus_rsp_t;

  // Host index, also the priority order (first is highest)
  typedef enum logic [1:0] {
    TestUtilHost,
    CoreD,
    CoreI
  } bus_host_e;

  typedef enum logic {
    Ram,
    TestUtilDevice
  } bus_device_e;

  // Register word offsets in the test utility window
  typedef enum logic [TuOffsetWidth-1:0] {
    SigBegin = 10'h000,
    SigEnd   = 10'h004,
    Halt     = 10'h008
  } tu_reg_e;

  typedef enum logic [1:0] {
    TuIdle,
    TuDump,
    TuDone
  } tu_state_e;

endpackage

/* design/sim_bus.sv */
// Fixed-priority shared bus, one grant per cycle, lowest host index first.
// Every device must answer exactly one cycle after its req. There is no stall path.
// Unmapped addresses are granted and answered by the bus itself with an error.
module sim_bus import sim_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     host_req_i        [NrHosts],
  input  bus_req_t host_req_data_i   [NrHosts],
  output logic     host_gnt_o        [NrHosts],
  output logic     host_rvalid_o     [NrHosts],
  output bus_rsp_t host_rsp_o        [NrHosts],

  output logic     device_req_o      [NrDevices],
  output bus_req_t device_req_data_o [NrDevices],
  input  logic     device_rvalid_i   [NrDevices],
  input  bus_rsp_t device_rsp_i      [NrDevices]
);

  logic        any_req;
  bus_host_e   sel_host;
  bus_req_t    sel_req;
  logic        dev_hit;
  bus_device_e dev_sel;

  // Routing of the transfer granted last cycle
  logic        rsp_pend_q;
  bus_host_e   rsp_host_q;
  bus_device_e rsp_dev_q;
  logic        rsp_nodev_q;

  logic        rsp_valid;
  bus_rsp_t    rsp_data;

  // Scan downward so the lowest requesting index is kept
  always_comb begin
    any_req  = 1'b0;
    sel_host = TestUtilHost;
    for (int h = NrHosts - 1; h >= 0; h--) begin
      if (host_req_i[h]) begin
        any_req  = 1'b1;
        sel_host = bus_host_e'(h);
      end
    end
  end

  assign sel_req = host_req_data_i[sel_host];

  // Address decode against the fixed map
  always_comb begin
    dev_hit = 1'b1;
    dev_sel = Ram;
    if ((sel_req.addr & RamMask) == RamBase) begin
      dev_sel = Ram;
    end else if ((sel_req.addr & TestUtilMask) == TestUtilBase) begin
      dev_sel = TestUtilDevice;
    end else begin
      dev_hit = 1'b0;
    end
  end

  // Grant is combinational in the request cycle
  always_comb begin
    for (int h = 0; h < NrHosts; h++) begin
      host_gnt_o[h] = any_req && (sel_host == bus_host_e'(h));
    end
  end

  // Payload goes to every device, only the decoded one sees req
  always_comb begin
    for (int d = 0; d < NrDevices; d++) begin
      device_req_o[d]      = any_req && dev_hit && (dev_sel == bus_device_e'(d));
      device_req_data_o[d] = sel_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_pend_q  <= 1'b0;
      rsp_host_q  <= TestUtilHost;
      rsp_dev_q   <= Ram;
      rsp_nodev_q <= 1'b0;
    end else begin
      rsp_pend_q <= any_req;
      if (any_req) begin
        rsp_host_q  <= sel_host;
        rsp_dev_q   <= dev_sel;
        rsp_nodev_q <= !dev_hit;
      end
    end
  end

  // Unmapped transfers get a bus-generated error with zero data
  always_comb begin
    if (rsp_nodev_q) begin
      rsp_valid = rsp_pend_q;
      rsp_data  = '{rdata: '0, err: 1'b1};
    end else begin
      rsp_valid = rsp_pend_q && device_rvalid_i[rsp_dev_q];
      rsp_data  = device_rsp_i[rsp_dev_q];
    end
  end

  always_comb begin
    for (int h = 0; h < NrHosts; h++) begin
      host_rvalid_o[h] = rsp_valid && (rsp_host_q == bus_host_e'(h));
      host_rsp_o[h]    = rsp_data;
    end
  end

endmodule

/* design/ram_1p.sv */
// Single-port word RAM, answers every req one cycle later.
// Only address bits above the byte offset index the array, upper bits are ignored.
module ram_1p import sim_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_i,
  input  bus_req_t req_data_i,
  output logic     rvalid_o,
  output bus_rsp_t rsp_o
);

  logic [31:0]             mem [RamSizeWords];
  logic [RamAddrWidth-1:0] word_idx;
  logic [31:0]             rdata_q;
  logic                    rvalid_q;

  assign word_idx = req_data_i.addr[2 +: RamAddrWidth];

  // Storage with per-lane writes
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (req_data_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_data_i.be[b]) begin
            mem[word_idx][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
          end
        end
      end
      // A write returns the old word, hosts ignore it
      rdata_q <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rsp_o    = '{rdata: rdata_q, err: 1'b0};

endmodule

/* design/riscv_testutil.sv */
// Test utility with signature range and halt registers and a signature dump engine.
// Register writes ignore byte enables. Bus errors on dump reads are not flagged.
// The dump relies on the bus answering one cycle after each grant.
module riscv_testutil import sim_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,

  // Register window
  input  logic        dev_req_i,
  input  bus_req_t    dev_req_data_i,
  output logic        dev_rvalid_o,
  output bus_rsp_t    dev_rsp_o,

  // Dump reads
  output logic        host_req_o,
  output bus_req_t    host_req_data_o,
  input  logic        host_gnt_i,
  input  logic        host_rvalid_i,
  input  bus_rsp_t    host_rsp_i,

  output logic        sig_valid_o,
  output logic [31:0] sig_data_o,
  output logic        done_o
);

  logic [TuOffsetWidth-1:0] reg_offset;
  logic [31:0]              sig_begin_q;
  logic [31:0]              sig_end_q;
  logic [31:0]              dump_addr_q;
  logic                     halt_q;
  logic                     issue_left;
  tu_state_e                state_q;
  logic                     dev_rvalid_q;
  bus_rsp_t                 dev_rsp_q;

  assign reg_offset = dev_req_data_i.addr[TuOffsetWidth-1:0];

  // Register writes, halt is a one-cycle pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sig_begin_q  <= '0;
      sig_end_q    <= '0;
      halt_q       <= 1'b0;
      dev_rvalid_q <= 1'b0;
    end else begin
      dev_rvalid_q <= dev_req_i;
      halt_q       <= 1'b0;
      if (dev_req_i && dev_req_data_i.we) begin
        case (reg_offset)
          SigBegin: sig_begin_q <= dev_req_data_i.wdata;
          SigEnd:   sig_end_q   <= dev_req_data_i.wdata;
          Halt:     halt_q      <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Read data and error for the register window
  always_ff @(posedge clk_i) begin
    if (dev_req_i) begin
      dev_rsp_q.err <= 1'b0;
      case (reg_offset)
        SigBegin: dev_rsp_q.rdata <= sig_begin_q;
        SigEnd:   dev_rsp_q.rdata <= sig_end_q;
        Halt:     dev_rsp_q.rdata <= '0;
        default: begin
          dev_rsp_q.rdata <= '0;
          dev_rsp_q.err   <= 1'b1;
        end
      endcase
    end
  end

  assign dev_rvalid_o = dev_rvalid_q;
  assign dev_rsp_o    = dev_rsp_q;

  // Words still to be requested
  assign issue_left = dump_addr_q < sig_end_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= TuIdle;
      dump_addr_q <= '0;
    end else begin
      case (state_q)
        TuIdle: begin
          if (halt_q) begin
            dump_addr_q <= sig_begin_q;
            // Empty range skips the dump
            state_q     <= (sig_end_q > sig_begin_q) ? TuDump : TuDone;
          end
        end
        TuDump: begin
          if (host_gnt_i) begin
            dump_addr_q <= dump_addr_q + 32'd4;
          end
          // Last response back once nothing is left to issue
          if (host_rvalid_i && !issue_left) begin
            state_q <= TuDone;
          end
        end
        default: ;
      endcase
    end
  end

  assign host_req_o      = (state_q == TuDump) && issue_left;
  assign host_req_data_o = '{addr: dump_addr_q, we: 1'b0, be: 4'hF, wdata: '0};

  // Each returned word goes straight out, the sink never stalls
  assign sig_valid_o = (state_q == TuDump) && host_rvalid_i;
  assign sig_data_o  = host_rsp_i.rdata;
  assign done_o      = (state_q == TuDone);

endmodule

/* design/compliance_sys.sv */
// Compliance test system without the core. Its data and fetch ports come out at the top.
// Hosts by priority: test utility, core data, core fetch. Devices: RAM and test utility.
module compliance_sys import sim_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,

  // Core data port
  input  logic        core_d_req_i,
  input  bus_req_t    core_d_req_data_i,
  output logic        core_d_gnt_o,
  output logic        core_d_rvalid_o,
  output bus_rsp_t    core_d_rsp_o,

  // Core fetch port, read only
  input  logic        core_i_req_i,
  input  logic [31:0] core_i_addr_i,
  output logic        core_i_gnt_o,
  output logic        core_i_rvalid_o,
  output bus_rsp_t    core_i_rsp_o,

  // Signature stream
  output logic        sig_valid_o,
  output logic [31:0] sig_data_o,
  output logic        done_o
);

  logic     host_req      [NrHosts];
  bus_req_t host_req_data [NrHosts];
  logic     host_gnt      [NrHosts];
  logic     host_rvalid   [NrHosts];
  bus_rsp_t host_rsp      [NrHosts];

  logic     device_req      [NrDevices];
  bus_req_t device_req_data [NrDevices];
  logic     device_rvalid   [NrDevices];
  bus_rsp_t device_rsp      [NrDevices];

  assign host_req[CoreD]      = core_d_req_i;
  assign host_req_data[CoreD] = core_d_req_data_i;
  assign host_req[CoreI]      = core_i_req_i;
  // Fetches are full-word reads
  assign host_req_data[CoreI] = '{addr: core_i_addr_i, we: 1'b0, be: 4'hF, wdata: '0};

  assign core_d_gnt_o    = host_gnt[CoreD];
  assign core_d_rvalid_o = host_rvalid[CoreD];
  assign core_d_rsp_o    = host_rsp[CoreD];
  assign core_i_gnt_o    = host_gnt[CoreI];
  assign core_i_rvalid_o = host_rvalid[CoreI];
  assign core_i_rsp_o    = host_rsp[CoreI];

  sim_bus u_bus (
    .clk_i             (clk_i          ),
    .rst_n_i           (rst_n_i        ),
    .host_req_i        (host_req       ),
    .host_req_data_i   (host_req_data  ),
    .host_gnt_o        (host_gnt       ),
    .host_rvalid_o     (host_rvalid    ),
    .host_rsp_o        (host_rsp       ),
    .device_req_o      (device_req     ),
    .device_req_data_o (device_req_data),
    .device_rvalid_i   (device_rvalid  ),
    .device_rsp_i      (device_rsp     )
  );

  // Shared instruction and data memory
  ram_1p u_ram (
    .clk_i      (clk_i              ),
    .rst_n_i    (rst_n_i            ),
    .req_i      (device_req[Ram]     ),
    .req_data_i (device_req_data[Ram]),
    .rvalid_o   (device_rvalid[Ram]  ),
    .rsp_o      (device_rsp[Ram]     )
  );

  riscv_testutil u_riscv_testutil (
    .clk_i           (clk_i                          ),
    .rst_n_i         (rst_n_i                        ),
    .dev_req_i       (device_req[TestUtilDevice]     ),
    .dev_req_data_i  (device_req_data[TestUtilDevice]),
    .dev_rvalid_o    (device_rvalid[TestUtilDevice]  ),
    .dev_rsp_o       (device_rsp[TestUtilDevice]     ),
    .host_req_o      (host_req[TestUtilHost]         ),
    .host_req_data_o (host_req_data[TestUtilHost]    ),
    .host_gnt_i      (host_gnt[TestUtilHost]         ),
    .host_rvalid_i   (host_rvalid[TestUtilHost]      ),
    .host_rsp_i      (host_rsp[TestUtilHost]         ),
    .sig_valid_o     (sig_valid_o                    ),
    .sig_data_o      (sig_data_o                     ),
    .done_o          (done_o                         )
  );

endmodule

/* tests/compliance_sys_checker.sv */
// Grant and response protocol assertions bound into the compliance system top level.
// Only the core ports and the test utility grant are observed.
module compliance_sys_checker (
  input logic clk_i,
  input logic rst_n_i,
  input logic tu_gnt_i,
  input logic d_req_i,
  input logic d_gnt_i,
  input logic d_rvalid_i,
  input logic i_req_i,
  input logic i_gnt_i,
  input logic i_rvalid_i,
  input logic done_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Number of failed assertions
  int unsigned fail_count = 0;

  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({tu_gnt_i, d_gnt_i, i_gnt_i}))
    else begin
      $error("more than one grant in a cycle");
      fail_count++;
    end

  a_d_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_n_i) d_gnt_i |-> d_req_i)
    else begin
      $error("core data grant without request");
      fail_count++;
    end

  a_i_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_n_i) i_gnt_i |-> i_req_i)
    else begin
      $error("core fetch grant without request");
      fail_count++;
    end

  // Response exactly one cycle after an accepted request
  a_d_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    d_rvalid_i == $past(d_req_i && d_gnt_i))
    else begin
      $error("core data rvalid out of step with its request");
      fail_count++;
    end

  a_i_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    i_rvalid_i == $past(i_req_i && i_gnt_i))
    else begin
      $error("core fetch rvalid out of step with its request");
      fail_count++;
    end

  a_done_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |=> done_i)
    else begin
      $error("done fell after rising");
      fail_count++;
    end

endmodule

bind compliance_sys compliance_sys_checker compliance_sys_checker_inst (
  .clk_i      (clk_i                 ),
  .rst_n_i    (rst_n_i               ),
  .tu_gnt_i   (host_gnt[TestUtilHost]),
  .d_req_i    (core_d_req_i          ),
  .d_gnt_i    (core_d_gnt_o          ),
  .d_rvalid_i (core_d_rvalid_o       ),
  .i_req_i    (core_i_req_i          ),
  .i_gnt_i    (core_i_gnt_o          ),
  .i_rvalid_i (core_i_rvalid_o       ),
  .done_i     (done_o                )
);

/* tests/compliance_sys_tb.sv */
// Case-file driven testbench. Run it from the project root so the case file path resolves.
// Case addresses are word aligned. RAM words are only read back after a case has written them.
module compliance_sys_tb import sim_bus_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned WaitCycles = 64;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        d_req;
  bus_req_t    d_req_data;
  logic        d_gnt;
  logic        d_rvalid;
  bus_rsp_t    d_rsp;
  logic        i_req;
  logic [31:0] i_addr;
  logic        i_gnt;
  logic        i_rvalid;
  bus_rsp_t    i_rsp;
  logic        sig_valid;
  logic [31:0] sig_data;
  logic        done;

  // Reference memory and test utility registers
  logic [31:0] model [RamSizeWords];
  logic [31:0] tu_begin;
  logic [31:0] tu_end;
  logic [15:0] lfsr = 16'd50851;
  int          case_errs;
  int          cases;
  int          failed;

  always #20 clk = ~clk;

  compliance_sys compliance_sys_inst (
    .clk_i             (clk       ),
    .rst_n_i           (rst_n     ),
    .core_d_req_i      (d_req     ),
    .core_d_req_data_i (d_req_data),
    .core_d_gnt_o      (d_gnt     ),
    .core_d_rvalid_o   (d_rvalid  ),
    .core_d_rsp_o      (d_rsp     ),
    .core_i_req_i      (i_req     ),
    .core_i_addr_i     (i_addr    ),
    .core_i_gnt_o      (i_gnt     ),
    .core_i_rvalid_o   (i_rvalid  ),
    .core_i_rsp_o      (i_rsp     ),
    .sig_valid_o       (sig_valid ),
    .sig_data_o        (sig_data  ),
    .done_o            (done      )
  );

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Expected response from the address map
  function automatic bus_rsp_t expect_rsp(input logic [31:0] addr);
    bus_rsp_t r;
    r = '{rdata: '0, err: 1'b1};
    if ((addr & RamMask) == RamBase) begin
      r = '{rdata: model[addr[2 +: RamAddrWidth]], err: 1'b0};
    end else if ((addr & TestUtilMask) == TestUtilBase) begin
      case (addr[TuOffsetWidth-1:0])
        SigBegin: r = '{rdata: tu_begin, err: 1'b0};
        SigEnd:   r = '{rdata: tu_end, err: 1'b0};
        Halt:     r = '{rdata: '0, err: 1'b0};
        default: ;
      endcase
    end
    return r;
  endfunction

  function automatic void model_write(input bus_req_t q);
    if ((q.addr & RamMask) == RamBase) begin
      for (int b = 0; b < 4; b++) begin
        if (q.be[b]) begin
          model[q.addr[2 +: RamAddrWidth]][8*b +: 8] = q.wdata[8*b +: 8];
        end
      end
    end else if ((q.addr & TestUtilMask) == TestUtilBase) begin
      if (q.addr[TuOffsetWidth-1:0] == SigBegin) begin
        tu_begin = q.wdata;
      end else if (q.addr[TuOffsetWidth-1:0] == SigEnd) begin
        tu_end = q.wdata;
      end
    end
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      case_errs++;
    end
  endtask

  function automatic logic probe(input string name);
    case (name)
      "core_d_gnt_o":    return d_gnt;
      "core_d_rvalid_o": return d_rvalid;
      "core_i_gnt_o":    return i_gnt;
      "core_i_rvalid_o": return i_rvalid;
      default:           return 1'b0;
    endcase
  endfunction

  // Samples at falling edges until the output is high
  task automatic wait_high(input string name);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!probe(name) && n < WaitCycles);
    if (!probe(name)) begin
      $display("Timed out after %0d cycles waiting for %s", WaitCycles, name);
      case_errs++;
    end
  endtask

  task automatic data_access(input bus_req_t q);
    bus_rsp_t exp;
    exp = expect_rsp(q.addr);
    @(posedge clk);
    d_req      <= 1'b1;
    d_req_data <= q;
    wait_high("core_d_gnt_o");
    @(posedge clk);
    d_req <= 1'b0;
    if (q.we) begin
      model_write(q);
    end
    wait_high("core_d_rvalid_o");
    compare("core_d_rsp_o.err", d_rsp.err, exp.err);
    if (!q.we) begin
      compare("core_d_rsp_o.rdata", d_rsp.rdata, exp.rdata);
    end
  endtask

  task automatic fetch_access(input logic [31:0] addr);
    bus_rsp_t exp;
    exp = expect_rsp(addr);
    @(posedge clk);
    i_req  <= 1'b1;
    i_addr <= addr;
    wait_high("core_i_gnt_o");
    @(posedge clk);
    i_req <= 1'b0;
    wait_high("core_i_rvalid_o");
    compare("core_i_rsp_o.err", i_rsp.err, exp.err);
    compare("core_i_rsp_o.rdata", i_rsp.rdata, exp.rdata);
  endtask

  // Data read and fetch of the next word raised in the same cycle
  task automatic pair_access(input logic [31:0] addr);
    bus_rsp_t exp_d;
    bus_rsp_t exp_i;
    exp_d = expect_rsp(addr);
    exp_i = expect_rsp(addr + 32'd4);
    @(posedge clk);
    d_req      <= 1'b1;
    d_req_data <= '{addr: addr, we: 1'b0, be: 4'hF, wdata: '0};
    i_req      <= 1'b1;
    i_addr     <= addr + 32'd4;
    @(negedge clk);
    compare("core_d_gnt_o", d_gnt, 1);
    compare("core_i_gnt_o", i_gnt, 0);
    @(posedge clk);
    d_req <= 1'b0;
    @(negedge clk);
    compare("core_d_rvalid_o", d_rvalid, 1);
    compare("core_d_rsp_o.rdata", d_rsp.rdata, exp_d.rdata);
    compare("core_i_gnt_o", i_gnt, 1);
    @(posedge clk);
    i_req <= 1'b0;
    @(negedge clk);
    compare("core_i_rvalid_o", i_rvalid, 1);
    compare("core_i_rsp_o.rdata", i_rsp.rdata, exp_i.rdata);
  endtask

  // Program the range, halt, then collect the stream while a core read waits
  task automatic dump_signature(input logic [31:0] sig_begin, input logic [31:0] sig_end);
    int          words;
    int          got;
    int          n;
    logic [31:0] addr;
    logic        core_back;
    bus_rsp_t    exp_core;
    data_access('{addr: TestUtilBase | 32'(SigBegin), we: 1'b1, be: 4'hF, wdata: sig_begin});
    data_access('{addr: TestUtilBase | 32'(SigEnd), we: 1'b1, be: 4'hF, wdata: sig_end});
    words     = (tu_end > tu_begin) ? (tu_end - tu_begin) / 4 : 0;
    addr      = tu_begin;
    got       = 0;
    n         = 0;
    core_back = 1'b0;
    exp_core  = expect_rsp(tu_begin);
    data_access('{addr: TestUtilBase | 32'(Halt), we: 1'b1, be: 4'hF, wdata: '0});
    @(posedge clk);
    d_req      <= 1'b1;
    d_req_data <= '{addr: tu_begin, we: 1'b0, be: 4'hF, wdata: '0};
    while (!(done && core_back) && n < WaitCycles + words) begin
      @(negedge clk);
      n++;
      if (sig_valid) begin
        compare("sig_data_o", sig_data, model[addr[2 +: RamAddrWidth]]);
        addr += 32'd4;
        got++;
      end
      if (d_rvalid) begin
        compare("core_d_rsp_o.rdata", d_rsp.rdata, exp_core.rdata);
        core_back = 1'b1;
      end
      if (d_req && d_gnt) begin
        if (got < words) begin
          $display("Core data request was granted while the signature dump was running");
          case_errs++;
        end
        @(posedge clk);
        d_req <= 1'b0;
      end
    end
    if (!(done && core_back)) begin
      $display("Signature dump or the waiting core read did not finish in time");
      case_errs++;
    end
    compare("signature word count", got, words);
    @(posedge clk);
    d_req <= 1'b0;
  endtask

  initial begin
    int          fd;
    int          code;
    string       line;
    string       op;
    string       wtxt;
    string       name;
    logic [31:0] addr;
    logic [31:0] be;
    logic [31:0] wdata;
    int unsigned assert_fails;
    rst_n      = 1'b0;
    d_req      = 1'b0;
    d_req_data = '0;
    i_req      = 1'b0;
    i_addr     = '0;
    tu_begin   = '0;
    tu_end     = '0;
    cases      = 0;
    failed     = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    fd = $fopen("tests/compliance_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file tests/compliance_cases.txt");
      failed++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code == 0 || line.len() == 0 || line[0] == "#") begin
          continue;
        end
        code = $sscanf(line, "%s %h %h %s %s", op, addr, be, wtxt, name);
        if (code != 5) begin
          continue;
        end
        if (wtxt == "random") begin
          rand_word(wdata);
        end else begin
          code = $sscanf(wtxt, "%h", wdata);
        end
        case_errs = 0;
        case (op)
          "W": data_access('{addr: addr, we: 1'b1, be: be[3:0], wdata: wdata});
          "R": data_access('{addr: addr, we: 1'b0, be: be[3:0], wdata: wdata});
          "F": fetch_access(addr);
          "P": pair_access(addr);
          "H": dump_signature(addr, wdata);
          default: begin
            $display("Unknown operation %s in case %s", op, name);
            case_errs++;
          end
        endcase
        cases++;
        if (case_errs == 0) begin
          $display("ok   %s", name);
        end else begin
          $display("FAIL %s (%0d errors)", name, case_errs);
          failed++;
        end
      end
      $fclose(fd);
    end
    assert_fails = compliance_sys_inst.compliance_sys_checker_inst.fail_count;
    $display("%0d cases run, %0d failed, %0d assertion failures", cases, failed, assert_fails);
    if (failed == 0 && assert_fails == 0 && cases > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* tests/compliance_cases.txt */
# op addr(hex) be(hex) wdata(hex or random) name
# op W write, R read, F fetch, P read addr with fetch of addr+4, H dump from addr to wdata
W 00000000 f 11223344 ram_write_full
W 00000004 f random   ram_write_random
W 00000008 f a5a5a5a5 ram_write_word
W 00000008 6 00beef00 ram_write_partial
W 0000000c f random   ram_write_random_2
W 00000010 3 random   ram_write_low_half
R 00000000 f 0        ram_read_full
R 00000004 f 0        ram_read_random
R 00000008 f 0        ram_read_partial
F 0000000c f 0        fetch_word
R 00040000 f 0        unmapped_read
W 00100000 f deadbeef unmapped_write
R 0002000c f 0        tu_bad_offset
W 00020000 f 00000008 tu_write_begin
R 00020000 f 0        tu_read_begin
R 00020008 f 0        tu_read_halt
P 00000000 f 0        priority_pair
H 00000000 f 0000000c signature_dump

/* list.f */
design/sim_bus_pkg.sv
design/sim_bus.sv
design/ram_1p.sv
design/riscv_testutil.sv
design/compliance_sys.sv
tests/compliance_sys_checker.sv
tests/compliance_sys_tb.sv
